// ==== apb_arbiter.sv ====
`timescale 1ns/1ps

module apb_arbiter (
    input  logic          ex_clk,
    input  logic          ex_rst,
    input  logic          f_req,
    input  rv_pkg::pc_t   f_addr,
    input  logic          l_req,
    input  logic          l_write,
    input  rv_pkg::pc_t   l_addr,
    input  rv_pkg::data_t l_wdata,
    input  rv_pkg::data_t prdata,
    input  logic          pready,
    output logic          f_done,
    output logic          l_done,
    output rv_pkg::data_t rdata,
    output rv_pkg::pc_t   paddr,
    output logic          psel,
    output logic          penable,
    output logic          pwrite,
    output rv_pkg::data_t pwdata
);
    typedef enum logic [1:0] {IDLE, SETUP, ACCESS} state_e;

    state_e state;
    logic   owner_lsu;

    always_ff @(posedge ex_clk or negedge ex_rst) begin
        if (!ex_rst) begin
            state     <= IDLE;
            owner_lsu <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    // Load/store wins a tie
                    if (l_req || f_req) begin
                        state     <= SETUP;
                        owner_lsu <= l_req;
                    end
                end
                SETUP:   state <= ACCESS;
                ACCESS:  state <= pready ? IDLE : ACCESS;
                default: state <= IDLE;
            endcase
        end
    end

    // Requesters hold their fields until done
    assign psel    = (state != IDLE);
    assign penable = (state == ACCESS);
    assign paddr   = owner_lsu ? l_addr : f_addr;
    assign pwrite  = owner_lsu && l_write;
    assign pwdata  = l_wdata;
    assign rdata   = prdata;
    assign f_done  = penable && pready && !owner_lsu;
    assign l_done  = penable && pready && owner_lsu;

    a_setup_first: assert property (@(posedge ex_clk) disable iff (!ex_rst)
        $rose(penable) |-> $past(psel && !penable));

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_rv_exec -f rv_exec_top.f -o sim_tb

out=$(./obj_dir/sim_tb) || true
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED"

// ==== rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode (
    input  logic              ex_clk,
    input  logic              ex_rst,
    input  logic              if_valid,
    input  rv_pkg::data_t     if_instr,
    input  rv_pkg::pc_t       if_pc,
    input  logic              stall_in,
    input  logic              flush,
    input  rv_pkg::reg_addr_t ex_busy_rd,
    input  logic              ex_busy,
    input  rv_pkg::reg_addr_t lsu_busy_rd,
    input  logic              lsu_busy,
    input  rv_pkg::data_t     rs1_data,
    input  rv_pkg::data_t     rs2_data,
    output rv_pkg::reg_addr_t rs1_addr,
    output rv_pkg::reg_addr_t rs2_addr,
    output logic              stall_out,
    output logic              id_valid,
    output rv_pkg::opcode_e   id_opcode,
    output rv_pkg::alu_op_e   id_alu,
    output rv_pkg::funct3_t   id_funct3,
    output rv_pkg::reg_addr_t id_rd,
    output rv_pkg::data_t     id_rs1_data,
    output rv_pkg::data_t     id_rs2_data,
    output rv_pkg::data_t     id_imm,
    output rv_pkg::pc_t       id_pc
);
    import rv_pkg::*;

    opcode_e opcode;
    alu_op_e alu;
    funct3_t funct3;
    data_t   imm;
    logic    use_rs1, use_rs2, writes_rd;
    logic    rs1_busy, rs2_busy, hazard;

    assign funct3   = if_instr[14:12];
    assign rs1_addr = if_instr[19:15];
    assign rs2_addr = if_instr[24:20];

    always_comb begin
        opcode = opcode_e'(if_instr[6:0]);
        // Anything unknown runs as a no-op
        if (!(opcode inside {RTYPE, ITYPE, LOAD, STORE, BRANCH,
                             JAL, JALR, LUI, AUIPC, SYSTEM})) begin
            opcode = FENCE;
        end
    end

    always_comb begin
        case (opcode)
            STORE:      imm = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
            BRANCH:     imm = {{20{if_instr[31]}}, if_instr[7], if_instr[30:25],
                               if_instr[11:8], 1'b0};
            LUI, AUIPC: imm = {if_instr[31:12], 12'b0};
            JAL:        imm = {{12{if_instr[31]}}, if_instr[19:12], if_instr[20],
                               if_instr[30:21], 1'b0};
            default:    imm = {{20{if_instr[31]}}, if_instr[31:20]};
        endcase
    end

    always_comb begin
        case (opcode)
            RTYPE, ITYPE: begin
                case (funct3)
                    3'b000:  alu = (opcode == RTYPE && if_instr[30]) ? SUB : ADD;
                    3'b001:  alu = SLL;
                    3'b010:  alu = SLT;
                    3'b011:  alu = SLTU;
                    3'b100:  alu = XOR;
                    3'b101:  alu = if_instr[30] ? SRA : SRL;
                    3'b110:  alu = OR;
                    default: alu = AND;
                endcase
            end
            BRANCH: begin
                case (funct3)
                    3'b001:  alu = NEQ;
                    3'b100:  alu = LT;
                    3'b101:  alu = GE;
                    3'b110:  alu = LTU;
                    3'b111:  alu = GEU;
                    default: alu = EQ;
                endcase
            end
            default: alu = ADD;
        endcase
    end

    assign use_rs1   = opcode inside {RTYPE, ITYPE, LOAD, STORE, BRANCH, JALR};
    assign use_rs2   = opcode inside {RTYPE, STORE, BRANCH};
    assign writes_rd = opcode inside {RTYPE, ITYPE, LOAD, JAL, JALR, LUI, AUIPC};

    // Producers not yet written: own output, execute, load/store
    assign rs1_busy = (id_valid && id_rd == rs1_addr) || (ex_busy && ex_busy_rd == rs1_addr)
                      || (lsu_busy && lsu_busy_rd == rs1_addr);
    assign rs2_busy = (id_valid && id_rd == rs2_addr) || (ex_busy && ex_busy_rd == rs2_addr)
                      || (lsu_busy && lsu_busy_rd == rs2_addr);
    assign hazard   = (use_rs1 && rs1_addr != '0 && rs1_busy)
                      || (use_rs2 && rs2_addr != '0 && rs2_busy);

    assign stall_out = stall_in || (if_valid && hazard);

    always_ff @(posedge ex_clk or negedge ex_rst) begin
        if (!ex_rst) begin
            id_valid <= 1'b0;
        end else if (flush) begin
            id_valid <= 1'b0;
        end else if (!stall_in) begin
            id_valid <= if_valid && !hazard;
        end
    end

    always_ff @(posedge ex_clk) begin
        if (!stall_in) begin
            id_opcode   <= opcode;
            id_alu      <= alu;
            id_funct3   <= funct3;
            // rd of zero marks an instruction with no result
            id_rd       <= writes_rd ? if_instr[11:7] : '0;
            id_rs1_data <= rs1_data;
            id_rs2_data <= rs2_data;
            id_imm      <= imm;
            id_pc       <= if_pc;
        end
    end

endmodule

// ==== rv_exec_top.f ====
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_lsu.sv
apb_arbiter.sv
rv_exec_top.sv
tb_wb_checker.sv
tb_rv_exec.sv

// ==== rv_exec_top.sv ====
`timescale 1ns/1ps

module rv_exec_top #(
    parameter rv_pkg::pc_t RESET_PC = 32'h0000_0000
) (
    input  logic              ex_clk,
    input  logic              ex_rst,
    output rv_pkg::pc_t       paddr,
    output logic              psel,
    output logic              penable,
    output logic              pwrite,
    output rv_pkg::data_t     pwdata,
    input  rv_pkg::data_t     prdata,
    input  logic              pready,
    output logic              wb_valid,
    output rv_pkg::reg_addr_t wb_rd,
    output rv_pkg::data_t     wb_data,
    output logic              change_pc,
    output rv_pkg::pc_t       next_pc
);
    import rv_pkg::*;

    logic      f_req, f_done, if_valid;
    pc_t       f_addr, if_pc;
    data_t     if_instr, bus_rdata;
    reg_addr_t rs1_addr, rs2_addr;
    data_t     rs1_data, rs2_data;
    logic      id_stall, id_valid;
    opcode_e   id_opcode;
    alu_op_e   id_alu;
    funct3_t   id_funct3;
    reg_addr_t id_rd;
    data_t     id_rs1_data, id_rs2_data, id_imm;
    pc_t       id_pc;
    logic      ex_stall, ex_valid, ex_busy;
    opcode_e   ex_opcode;
    reg_addr_t ex_rd, ex_busy_rd;
    data_t     ex_result, ex_store_data;
    logic      lsu_stall, l_req, l_write, l_done, lsu_busy;
    pc_t       l_addr;
    data_t     l_wdata;
    reg_addr_t lsu_busy_rd;

    rv_fetch #(.RESET_PC(RESET_PC)) u_fetch (
        .ex_clk(ex_clk), .ex_rst(ex_rst), .stall(id_stall),
        .change_pc(change_pc), .next_pc(next_pc),
        .bus_done(f_done), .bus_rdata(bus_rdata), .bus_req(f_req), .bus_addr(f_addr),
        .if_valid(if_valid), .if_instr(if_instr), .if_pc(if_pc)
    );

    rv_decode u_decode (
        .ex_clk(ex_clk), .ex_rst(ex_rst),
        .if_valid(if_valid), .if_instr(if_instr), .if_pc(if_pc),
        .stall_in(ex_stall), .flush(change_pc),
        .ex_busy_rd(ex_busy_rd), .ex_busy(ex_busy),
        .lsu_busy_rd(lsu_busy_rd), .lsu_busy(lsu_busy),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .stall_out(id_stall),
        .id_valid(id_valid), .id_opcode(id_opcode), .id_alu(id_alu),
        .id_funct3(id_funct3), .id_rd(id_rd),
        .id_rs1_data(id_rs1_data), .id_rs2_data(id_rs2_data),
        .id_imm(id_imm), .id_pc(id_pc)
    );

    rv_regfile u_regfile (
        .ex_clk(ex_clk), .ex_rst(ex_rst),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    rv_execute u_execute (
        .ex_clk(ex_clk), .ex_rst(ex_rst),
        .id_valid(id_valid), .id_opcode(id_opcode), .id_alu(id_alu),
        .id_funct3(id_funct3), .id_rd(id_rd),
        .id_rs1_data(id_rs1_data), .id_rs2_data(id_rs2_data),
        .id_imm(id_imm), .id_pc(id_pc),
        .stall_in(lsu_stall), .stall_out(ex_stall),
        .change_pc(change_pc), .next_pc(next_pc),
        .ex_valid(ex_valid), .ex_opcode(ex_opcode), .ex_rd(ex_rd),
        .ex_result(ex_result), .ex_store_data(ex_store_data),
        .ex_busy_rd(ex_busy_rd), .ex_busy(ex_busy)
    );

    rv_lsu u_lsu (
        .ex_clk(ex_clk), .ex_rst(ex_rst),
        .ex_valid(ex_valid), .ex_opcode(ex_opcode), .ex_rd(ex_rd),
        .ex_result(ex_result), .ex_store_data(ex_store_data),
        .bus_done(l_done), .bus_rdata(bus_rdata), .stall_out(lsu_stall),
        .bus_req(l_req), .bus_write(l_write), .bus_addr(l_addr), .bus_wdata(l_wdata),
        .lsu_busy_rd(lsu_busy_rd), .lsu_busy(lsu_busy),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    apb_arbiter u_arbiter (
        .ex_clk(ex_clk), .ex_rst(ex_rst),
        .f_req(f_req), .f_addr(f_addr),
        .l_req(l_req), .l_write(l_write), .l_addr(l_addr), .l_wdata(l_wdata),
        .prdata(prdata), .pready(pready),
        .f_done(f_done), .l_done(l_done), .rdata(bus_rdata),
        .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata)
    );

endmodule

// ==== rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute (
    input  logic              ex_clk,
    input  logic              ex_rst,
    input  logic              id_valid,
    input  rv_pkg::opcode_e   id_opcode,
    input  rv_pkg::alu_op_e   id_alu,
    input  rv_pkg::funct3_t   id_funct3,
    input  rv_pkg::reg_addr_t id_rd,
    input  rv_pkg::data_t     id_rs1_data,
    input  rv_pkg::data_t     id_rs2_data,
    input  rv_pkg::data_t     id_imm,
    input  rv_pkg::pc_t       id_pc,
    input  logic              stall_in,
    output logic              stall_out,
    output logic              change_pc,
    output rv_pkg::pc_t       next_pc,
    output logic              ex_valid,
    output rv_pkg::opcode_e   ex_opcode,
    output rv_pkg::reg_addr_t ex_rd,
    output rv_pkg::data_t     ex_result,
    output rv_pkg::data_t     ex_store_data,
    output rv_pkg::reg_addr_t ex_busy_rd,
    output logic              ex_busy
);
    import rv_pkg::*;

    data_t      op_a, op_b, alu_value;
    logic [4:0] shamt;
    logic       is_jump, take, mem_bad;
    pc_t        target;

    assign is_jump = (id_opcode == JAL) || (id_opcode == JALR);

    always_comb begin
        if (id_opcode == JAL || id_opcode == AUIPC) begin
            op_a = id_pc;
        end else if (id_opcode == LUI) begin
            op_a = '0;
        end else begin
            op_a = id_rs1_data;
        end
        op_b  = (id_opcode == RTYPE || id_opcode == BRANCH) ? id_rs2_data : id_imm;
        shamt = op_b[4:0];
        case (id_alu)
            ADD:      alu_value = op_a + op_b;
            SUB:      alu_value = op_a - op_b;
            SLT, LT:  alu_value = {31'b0, $signed(op_a) < $signed(op_b)};
            SLTU, LTU: alu_value = {31'b0, op_a < op_b};
            XOR:      alu_value = op_a ^ op_b;
            OR:       alu_value = op_a | op_b;
            AND:      alu_value = op_a & op_b;
            SLL:      alu_value = op_a << shamt;
            SRL:      alu_value = op_a >> shamt;
            SRA:      alu_value = $signed(op_a) >>> shamt;
            EQ:       alu_value = {31'b0, op_a == op_b};
            NEQ:      alu_value = {31'b0, op_a != op_b};
            GE:       alu_value = {31'b0, $signed(op_a) >= $signed(op_b)};
            GEU:      alu_value = {31'b0, op_a >= op_b};
            default:  alu_value = '0;
        endcase
    end

    assign take    = (id_opcode == BRANCH) ? alu_value[0] : is_jump;
    assign target  = (id_opcode == JALR) ? {alu_value[31:1], 1'b0} : id_pc + id_imm;
    // Only word loads and stores exist
    assign mem_bad = (id_opcode == LOAD || id_opcode == STORE) && id_funct3 != F3_WORD;

    assign stall_out  = stall_in;
    assign ex_busy    = ex_valid;
    assign ex_busy_rd = ex_rd;

    always_ff @(posedge ex_clk or negedge ex_rst) begin
        if (!ex_rst) begin
            ex_valid  <= 1'b0;
            change_pc <= 1'b0;
        end else begin
            change_pc <= 1'b0;
            // The instruction behind a redirect is younger and is dropped
            if (!stall_in) begin
                ex_valid  <= id_valid && !change_pc;
                change_pc <= id_valid && !change_pc && take;
            end
        end
    end

    always_ff @(posedge ex_clk) begin
        if (!stall_in) begin
            next_pc       <= target;
            ex_opcode     <= mem_bad ? FENCE : id_opcode;
            ex_rd         <= mem_bad ? '0 : id_rd;
            ex_result     <= is_jump ? id_pc + 32'd4 : alu_value;
            ex_store_data <= id_rs2_data;
        end
    end

    a_redirect_pulse: assert property (@(posedge ex_clk) disable iff (!ex_rst)
        change_pc |=> !change_pc);

endmodule

// ==== rv_fetch.sv ====
`timescale 1ns/1ps

module rv_fetch #(
    parameter rv_pkg::pc_t RESET_PC = 32'h0000_0000
) (
    input  logic          ex_clk,
    input  logic          ex_rst,
    input  logic          stall,
    input  logic          change_pc,
    input  rv_pkg::pc_t   next_pc,
    input  logic          bus_done,
    input  rv_pkg::data_t bus_rdata,
    output logic          bus_req,
    output rv_pkg::pc_t   bus_addr,
    output logic          if_valid,
    output rv_pkg::data_t if_instr,
    output rv_pkg::pc_t   if_pc
);
    import rv_pkg::*;

    pc_t  pc;
    logic stale;
    logic issue;

    // New fetch once the output slot is free or taken this cycle
    assign issue = !bus_req && (!if_valid || !stall) && !change_pc;

    always_ff @(posedge ex_clk or negedge ex_rst) begin
        if (!ex_rst) begin
            pc       <= RESET_PC;
            bus_req  <= 1'b0;
            stale    <= 1'b0;
            if_valid <= 1'b0;
        end else begin
            if (change_pc) begin
                pc <= next_pc;
            end else if (issue) begin
                pc <= pc + 32'd4;
            end
            if (issue) begin
                bus_req <= 1'b1;
            end else if (bus_done) begin
                bus_req <= 1'b0;
            end
            // Fetch in flight during a redirect is dropped on return
            if (bus_done) begin
                stale <= 1'b0;
            end else if (change_pc && bus_req) begin
                stale <= 1'b1;
            end
            if (change_pc) begin
                if_valid <= 1'b0;
            end else if (bus_done && !stale) begin
                if_valid <= 1'b1;
            end else if (!stall) begin
                if_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge ex_clk) begin
        if (issue) begin
            bus_addr <= pc;
        end
        if (bus_done) begin
            if_instr <= bus_rdata;
            if_pc    <= bus_addr;
        end
    end

    a_addr_stable: assert property (@(posedge ex_clk) disable iff (!ex_rst)
        bus_req && !bus_done |=> bus_addr == $past(bus_addr));

endmodule

// ==== rv_lsu.sv ====
`timescale 1ns/1ps

module rv_lsu (
    input  logic              ex_clk,
    input  logic              ex_rst,
    input  logic              ex_valid,
    input  rv_pkg::opcode_e   ex_opcode,
    input  rv_pkg::reg_addr_t ex_rd,
    input  rv_pkg::data_t     ex_result,
    input  rv_pkg::data_t     ex_store_data,
    input  logic              bus_done,
    input  rv_pkg::data_t     bus_rdata,
    output logic              stall_out,
    output logic              bus_req,
    output logic              bus_write,
    output rv_pkg::pc_t       bus_addr,
    output rv_pkg::data_t     bus_wdata,
    output rv_pkg::reg_addr_t lsu_busy_rd,
    output logic              lsu_busy,
    output logic              wb_valid,
    output rv_pkg::reg_addr_t wb_rd,
    output rv_pkg::data_t     wb_data
);
    import rv_pkg::*;

    logic pend;
    logic is_mem;
    logic accept;

    assign is_mem = (ex_opcode == LOAD) || (ex_opcode == STORE);
    assign accept = ex_valid && !pend;

    assign stall_out = pend;
    assign bus_req   = pend;

    // wb_rd doubles as the destination of a pending load
    assign lsu_busy    = wb_valid || (pend && !bus_write);
    assign lsu_busy_rd = wb_rd;

    always_ff @(posedge ex_clk or negedge ex_rst) begin
        if (!ex_rst) begin
            pend     <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= 1'b0;
            if (pend) begin
                if (bus_done) begin
                    pend     <= 1'b0;
                    wb_valid <= !bus_write && wb_rd != '0;
                end
            end else if (ex_valid) begin
                pend     <= is_mem;
                wb_valid <= !is_mem && ex_rd != '0;
            end
        end
    end

    always_ff @(posedge ex_clk) begin
        if (accept) begin
            wb_rd     <= ex_rd;
            wb_data   <= ex_result;
            bus_write <= (ex_opcode == STORE);
            bus_addr  <= ex_result;
            bus_wdata <= ex_store_data;
        end else if (pend && bus_done) begin
            wb_data <= bus_rdata;
        end
    end

endmodule

// ==== rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN     = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 1 << REG_AW;

    typedef logic [XLEN-1:0]   data_t;
    typedef logic [XLEN-1:0]   pc_t;
    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [2:0]        funct3_t;

    // funct3 of LW and SW
    localparam funct3_t F3_WORD = 3'b010;

    // Compare ops leave their result in bit 0
    typedef enum logic [3:0] {
        ADD, SUB, SLT, SLTU, XOR, OR, AND, SLL,
        SRL, SRA, EQ, NEQ, LT, GE, LTU, GEU
    } alu_op_e;

    typedef enum logic [6:0] {
        RTYPE  = 7'b0110011,
        ITYPE  = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        SYSTEM = 7'b1110011,
        FENCE  = 7'b0001111
    } opcode_e;

endpackage

// ==== rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
    input  logic              ex_clk,
    input  logic              ex_rst,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    output rv_pkg::data_t     rs1_data,
    output rv_pkg::data_t     rs2_data,
    input  logic              wb_valid,
    input  rv_pkg::reg_addr_t wb_rd,
    input  rv_pkg::data_t     wb_data
);
    import rv_pkg::*;

    data_t regs [NUM_REGS];

    always_ff @(posedge ex_clk) begin
        if (wb_valid && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // x0 reads as zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    a_no_x0_wb: assert property (@(posedge ex_clk) disable iff (!ex_rst)
        wb_valid |-> wb_rd != '0);

endmodule

// ==== tb_rv_exec.sv ====
`timescale 1ns/1ps

module tb_rv_exec;
    import rv_pkg::*;

    localparam pc_t RESET_PC  = 32'h0000_0100;
    localparam pc_t DATA_ADDR = 32'h0000_0204;
    localparam int  MEM_WORDS = 256;

    logic      ex_clk;
    logic      ex_rst;
    pc_t       paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    data_t     pwdata;
    data_t     prdata;
    logic      pready;
    logic      wb_valid;
    reg_addr_t wb_rd;
    data_t     wb_data;
    logic      change_pc;
    pc_t       next_pc;
    int        wb_seen;
    int        redir_seen;
    int        chk_errors;

    data_t     mem [MEM_WORDS];

    // Program table, a target of zero means no redirect
    string     t_name [64];
    data_t     t_instr [64];
    int        t_rd [64];
    data_t     t_val [64];
    pc_t       t_tgt [64];
    int        n_steps;
    int        n_wb;
    int        n_redir;
    int        tb_errors;
    int        timeouts;

    rv_exec_top #(.RESET_PC(RESET_PC)) DUT (
        .ex_clk(ex_clk), .ex_rst(ex_rst),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .change_pc(change_pc), .next_pc(next_pc)
    );

    tb_wb_checker u_check (
        .ex_clk(ex_clk), .ex_rst(ex_rst),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .change_pc(change_pc), .next_pc(next_pc),
        .wb_count(wb_seen), .redir_count(redir_seen), .err_count(chk_errors)
    );

    initial begin
        ex_clk = 1'b0;
        forever #50 ex_clk = ~ex_clk;
    end

    function automatic data_t r_type(input int f7, input int rs2, input int rs1,
                                     input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], RTYPE};
    endfunction

    function automatic data_t i_type(input opcode_e opc, input int imm, input int rs1,
                                     input int f3, input int rd);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic data_t s_type(input int imm, input int rs2, input int rs1,
                                     input int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], STORE};
    endfunction

    function automatic data_t b_type(input int off, input int rs2, input int rs1,
                                     input int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], BRANCH};
    endfunction

    function automatic data_t u_type(input opcode_e opc, input int imm20, input int rd);
        return {imm20[19:0], rd[4:0], opc};
    endfunction

    function automatic data_t j_type(input int off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], JAL};
    endfunction

    task automatic add_step(input string name, input data_t instr, input int rd,
                            input data_t val, input pc_t tgt);
        t_name[n_steps]  = name;
        t_instr[n_steps] = instr;
        t_rd[n_steps]    = rd;
        t_val[n_steps]   = val;
        t_tgt[n_steps]   = tgt;
        n_steps++;
    endtask

    // One entry per word from RESET_PC upward
    task automatic build_program();
        add_step("addi_pos", i_type(ITYPE, 5, 0, 0, 1), 1, 32'h0000_0005, 0);
        add_step("addi_neg", i_type(ITYPE, -3, 0, 0, 2), 2, 32'hFFFF_FFFD, 0);
        add_step("add_dep", r_type(0, 2, 1, 0, 3), 3, 32'h0000_0002, 0);
        add_step("sub", r_type(32, 2, 1, 0, 4), 4, 32'h0000_0008, 0);
        add_step("slt_neg", r_type(0, 1, 2, 2, 5), 5, 32'h0000_0001, 0);
        add_step("sltu_neg", r_type(0, 1, 2, 3, 6), 6, 32'h0000_0000, 0);
        add_step("xori", i_type(ITYPE, 'h0F0, 2, 4, 7), 7, 32'hFFFF_FF0D, 0);
        add_step("or", r_type(0, 4, 1, 6, 8), 8, 32'h0000_000D, 0);
        add_step("andi", i_type(ITYPE, 'h3C3, 7, 7, 9), 9, 32'h0000_0301, 0);
        add_step("addi_shamt", i_type(ITYPE, 36, 0, 0, 11), 11, 32'h0000_0024, 0);
        add_step("sll_low5", r_type(0, 11, 1, 1, 10), 10, 32'h0000_0050, 0);
        add_step("srl_low5", r_type(0, 11, 2, 5, 12), 12, 32'h0FFF_FFFF, 0);
        add_step("sra_low5", r_type(32, 11, 2, 5, 13), 13, 32'hFFFF_FFFF, 0);
        add_step("srai", i_type(ITYPE, 'h401, 2, 5, 14), 14, 32'hFFFF_FFFE, 0);
        add_step("lui", u_type(LUI, 'h12345, 15), 15, 32'h1234_5000, 0);
        add_step("auipc", u_type(AUIPC, 1, 16), 16, 32'h0000_113C, 0);
        add_step("beq_taken", b_type(8, 1, 1, 0), 0, 0, 32'h0000_0148);
        add_step("skip_beq", i_type(ITYPE, 99, 0, 0, 17), 0, 0, 0);
        add_step("bne_not_taken", b_type(8, 1, 1, 1), 0, 0, 0);
        add_step("addi_after_bne", i_type(ITYPE, 7, 0, 0, 17), 17, 32'h0000_0007, 0);
        add_step("jal_link", j_type(12, 18), 18, 32'h0000_0154, 32'h0000_015C);
        add_step("skip_jal_a", i_type(ITYPE, 1, 0, 0, 19), 0, 0, 0);
        add_step("skip_jal_b", i_type(ITYPE, 2, 0, 0, 19), 0, 0, 0);
        add_step("addi_base", i_type(ITYPE, 'h160, 0, 0, 20), 20, 32'h0000_0160, 0);
        add_step("jalr_link", i_type(JALR, 13, 20, 0, 21), 21, 32'h0000_0164, 32'h0000_016C);
        add_step("skip_jalr_a", i_type(ITYPE, 1, 0, 0, 22), 0, 0, 0);
        add_step("skip_jalr_b", i_type(ITYPE, 2, 0, 0, 22), 0, 0, 0);
        add_step("jal_x0", j_type(8, 0), 0, 0, 32'h0000_0174);
        add_step("skip_jal_x0", i_type(ITYPE, 1, 0, 0, 23), 0, 0, 0);
        add_step("addi_data", i_type(ITYPE, 'h200, 0, 0, 24), 24, 32'h0000_0200, 0);
        add_step("lui_word", u_type(LUI, 'hCAFEB, 25), 25, 32'hCAFE_B000, 0);
        add_step("addi_word", i_type(ITYPE, -1346, 25, 0, 25), 25, 32'hCAFE_AABE, 0);
        add_step("sw", s_type(4, 25, 24, 2), 0, 0, 0);
        add_step("lw", i_type(LOAD, 4, 24, 2, 26), 26, 32'hCAFE_AABE, 0);
        add_step("add_load", r_type(0, 1, 26, 0, 27), 27, 32'hCAFE_AAC3, 0);
        add_step("spin", j_type(0, 0), 0, 0, 32'h0000_018C);
    endtask

    // APB slave with 0 to 3 wait cycles per transfer
    task automatic serve_apb();
        int wait_left;
        wait_left = 0;
        forever begin
            @(negedge ex_clk);
            pready = 1'b0;
            if (psel && !penable) begin
                wait_left = $urandom % 4;
            end else if (psel && penable) begin
                if (wait_left == 0) begin
                    pready = 1'b1;
                    if (pwrite) begin
                        mem[paddr[9:2]] = pwdata;
                    end else begin
                        prdata = mem[paddr[9:2]];
                    end
                end else begin
                    wait_left--;
                end
            end
        end
    endtask

    task automatic wait_first_fetch();
        int cycles;
        for (cycles = 0; cycles < 20 && !psel; cycles++) begin
            @(negedge ex_clk);
            if (!psel && (penable || wb_valid || change_pc)) begin
                $display("Bus or result outputs went high before the first fetch");
                tb_errors++;
            end
        end
        if (!psel) begin
            $display("Timeout: no APB transfer started after reset");
            timeouts++;
        end else begin
            if (penable) begin
                $display("First fetch skipped its APB setup cycle");
                tb_errors++;
            end
            if (paddr !== RESET_PC) begin
                $display("ERROR first_fetch: paddr expected %h actual %h", RESET_PC, paddr);
                tb_errors++;
            end
        end
    endtask

    task automatic wait_program_done();
        int cycles;
        for (cycles = 0; cycles < 4000 && !(wb_seen == n_wb && redir_seen == n_redir);
             cycles++) begin
            @(negedge ex_clk);
        end
        if (!(wb_seen == n_wb && redir_seen == n_redir)) begin
            $display("Timeout: program did not finish, %0d of %0d results, %0d of %0d redirects",
                     wb_seen, n_wb, redir_seen, n_redir);
            timeouts++;
        end
    endtask

    initial begin
        int  i;
        pc_t addr;
        void'($urandom(23111));
        ex_rst    = 1'b0;
        pready    = 1'b0;
        prdata    = '0;
        tb_errors = 0;
        timeouts  = 0;
        n_steps   = 0;
        n_wb      = 0;
        n_redir   = 0;
        for (i = 0; i < MEM_WORDS; i++) begin
            addr   = i * 4;
            mem[i] = addr ^ 32'hA5A5_5A5A;
        end
        build_program();
        for (i = 0; i < n_steps; i++) begin
            mem[(RESET_PC >> 2) + i] = t_instr[i];
            if (t_rd[i] != 0) begin
                u_check.expect_wb(t_name[i], t_rd[i], t_val[i]);
                n_wb++;
            end
            if (t_tgt[i] != '0) begin
                u_check.expect_redirect(t_name[i], t_tgt[i]);
                n_redir++;
            end
        end
        fork
            serve_apb();
        join_none
        repeat (4) begin
            @(negedge ex_clk);
            if (psel || penable || wb_valid || change_pc) begin
                $display("Bus or result outputs active during reset");
                tb_errors++;
            end
        end
        ex_rst = 1'b1;
        wait_first_fetch();
        wait_program_done();
        // Let the spin loop run to catch stray results
        repeat (20) @(negedge ex_clk);
        if (mem[DATA_ADDR >> 2] !== 32'hCAFE_AABE) begin
            $display("ERROR mem_sw: expected %h actual %h", 32'hCAFE_AABE, mem[DATA_ADDR >> 2]);
            tb_errors++;
        end
        $display("Errors: checker %0d, testbench %0d, timeouts %0d",
                 chk_errors, tb_errors, timeouts);
        if (chk_errors == 0 && tb_errors == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== tb_wb_checker.sv ====
`timescale 1ns/1ps

module tb_wb_checker (
    input  logic              ex_clk,
    input  logic              ex_rst,
    input  logic              wb_valid,
    input  rv_pkg::reg_addr_t wb_rd,
    input  rv_pkg::data_t     wb_data,
    input  logic              change_pc,
    input  rv_pkg::pc_t       next_pc,
    output int                wb_count,
    output int                redir_count,
    output int                err_count
);
    import rv_pkg::*;

    string wb_name [64];
    int    wb_exp_rd [64];
    data_t wb_exp_val [64];
    int    n_wb = 0;

    string pc_name [64];
    pc_t   pc_exp [64];
    int    n_redir = 0;

    function void expect_wb(input string name, input int rd, input data_t val);
        wb_name[n_wb]    = name;
        wb_exp_rd[n_wb]  = rd;
        wb_exp_val[n_wb] = val;
        n_wb++;
    endfunction

    function void expect_redirect(input string name, input pc_t target);
        pc_name[n_redir] = name;
        pc_exp[n_redir]  = target;
        n_redir++;
    endfunction

    always @(negedge ex_clk) begin
        int errs;
        errs = 0;
        if (!ex_rst) begin
            wb_count    <= 0;
            redir_count <= 0;
            err_count   <= 0;
        end else begin
            if (wb_valid) begin
                if (wb_count >= n_wb) begin
                    $display("Unexpected writeback to x%0d (%h) after all expected results",
                             wb_rd, wb_data);
                    errs++;
                end else begin
                    if (wb_rd != wb_exp_rd[wb_count][4:0]) begin
                        $display("ERROR %s: rd expected x%0d actual x%0d",
                                 wb_name[wb_count], wb_exp_rd[wb_count], wb_rd);
                        errs++;
                    end
                    if (wb_data !== wb_exp_val[wb_count]) begin
                        $display("ERROR %s: data expected %h actual %h",
                                 wb_name[wb_count], wb_exp_val[wb_count], wb_data);
                        errs++;
                    end
                    wb_count <= wb_count + 1;
                end
            end
            if (change_pc) begin
                if (redir_count < n_redir) begin
                    if (next_pc !== pc_exp[redir_count]) begin
                        $display("ERROR %s: next_pc expected %h actual %h",
                                 pc_name[redir_count], pc_exp[redir_count], next_pc);
                        errs++;
                    end
                    redir_count <= redir_count + 1;
                end else if (n_redir > 0 && next_pc !== pc_exp[n_redir-1]) begin
                    // Spin loop at the end keeps jumping to itself
                    $display("ERROR %s: next_pc expected %h actual %h",
                             pc_name[n_redir-1], pc_exp[n_redir-1], next_pc);
                    errs++;
                end
            end
            err_count <= err_count + errs;
        end
    end

endmodule
